//--- src/timer_pkg.sv
package timer_pkg;

    // register word addresses, octal.
    localparam logic [3:0] addr_reload  = 4'o06;
    localparam logic [3:0] addr_counter = 4'o10;
    localparam logic [3:0] addr_control = 4'o12;

    // control/status bit positions.
    localparam int bit_stop       = 0;
    localparam int bit_wraparound = 1;
    localparam int bit_stopenable = 2;
    localparam int bit_oneshot    = 3;
    localparam int bit_run        = 4;
    localparam int bit_div16      = 5;
    localparam int bit_div4       = 6;
    // ready flag position in control read data.
    localparam int bit_done       = 7;

    // clocks between base ticks.
    localparam int tick_period = 1067;

    // divider restart value.
    localparam logic [10:0] div_reload = 11'(tick_period - 1);

    // loaded in place of a zero reload value.
    localparam logic [15:0] reload_zero_value = 16'hffff;

    // decoded register target.
    typedef enum logic [1:0] {
        sel_none,
        sel_reload,
        sel_counter,
        sel_control
    } reg_sel_t;

endpackage

//--- src/timer_regs.sv
module timer_regs
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        ce,
    input  logic        regwr,
    input  logic        regrd,
    input  logic [3:0]  addr,
    input  logic [15:0] data_i,
    input  logic [15:0] count,
    input  logic [6:0]  control,
    input  logic        ready,
    output logic [15:0] data_o,
    output reg_sel_t    reg_sel,
    output logic [15:0] counter_reload,
    output logic        ctl_read_ack
);

    logic        reg_write;
    logic        reg_read;
    logic [15:0] ctl_word;

    // address decode.
    always_comb begin
        case (addr)
            addr_reload:  reg_sel = sel_reload;
            addr_counter: reg_sel = sel_counter;
            addr_control: reg_sel = sel_control;
            default:      reg_sel = sel_none;
        endcase
    end

    // write wins over read.
    assign reg_write = ce & regwr;
    assign reg_read  = ce & regrd & ~regwr;

    assign ctl_read_ack = reg_read & (reg_sel == sel_control);

    // upper byte reads as ones.
    always_comb begin
        ctl_word           = 16'hff00;
        ctl_word[6:0]      = control;
        ctl_word[bit_done] = ready;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            counter_reload <= '0;
        end else if (reg_write && reg_sel == sel_reload) begin
            counter_reload <= data_i;
        end
    end

    // registered read data, held between reads.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_o <= '0;
        end else if (reg_read) begin
            case (reg_sel)
                sel_reload:  data_o <= counter_reload;
                sel_counter: data_o <= count;
                sel_control: data_o <= ctl_word;
                default:     data_o <= data_o;
            endcase
        end
    end

endmodule

//--- src/timer_tick_gen.sv
module timer_tick_gen
    import timer_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic counting,
    input  logic ctl_div16,
    input  logic ctl_div4,
    output logic count_pulse
);

    logic [10:0] div_count;
    logic [5:0]  prescaler;
    logic        base_tick;
    logic        phase_ok;

    // base tick when the divider hits zero.
    assign base_tick = (div_count == 11'd0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
        end else if (base_tick) begin
            div_count <= div_reload;
        end else begin
            div_count <= div_count - 11'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prescaler <= '0;
        end else if (base_tick) begin
            prescaler <= prescaler + 6'd1;
        end
    end

    // prescaler phase picked by the mode bits.
    always_comb begin
        case ({ctl_div4, ctl_div16})
            2'b00:   phase_ok = 1'b1;
            2'b01:   phase_ok = (prescaler == 6'd0);
            // div by 8 of the base tick.
            2'b10:   phase_ok = (prescaler[2:0] == 3'd0);
            default: phase_ok = (prescaler == 6'd0);
        endcase
    end

    assign count_pulse = base_tick & phase_ok & counting;

endmodule

//--- src/timer_counter.sv
module timer_counter
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        ce,
    input  logic        regwr,
    input  logic        regrd,
    input  reg_sel_t    reg_sel,
    input  logic [15:0] data_i,
    input  logic [15:0] counter_reload,
    input  logic        ctl_read_ack,
    input  logic        count_pulse,
    output logic [15:0] count,
    output logic [6:0]  control,
    output logic        ready,
    output logic        counting,
    output logic        ctl_div16,
    output logic        ctl_div4
);

    logic        ctl_write;
    logic        ctl_access;
    logic        at_zero;
    logic [15:0] restart_value;

    assign ctl_write  = ce & regwr & (reg_sel == sel_control);
    // any control access holds off counting for that edge.
    assign ctl_access = ce & (regwr | regrd) & (reg_sel == sel_control);

    assign counting  = control[bit_run] & ~control[bit_stop];
    assign ctl_div16 = control[bit_div16];
    assign ctl_div4  = control[bit_div4];

    assign at_zero = (count == 16'd0);

    // a zero reload means a full 64k period.
    assign restart_value = (counter_reload == 16'd0) ? reload_zero_value : counter_reload;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            control <= '0;
            count   <= '0;
            ready   <= 1'b0;
        end else if (ctl_write) begin
            control <= data_i[6:0];
            if (data_i[bit_run]) begin
                count <= counter_reload;
            end
        end else if (ctl_access) begin
            // status read clears ready.
            if (ctl_read_ack) begin
                ready <= 1'b0;
            end
        end else if (counting) begin
            if (count_pulse) begin
                if (at_zero && !control[bit_wraparound]) begin
                    count <= restart_value;
                    // one-shot stops after the restart.
                    if (control[bit_oneshot]) begin
                        control[bit_run] <= 1'b0;
                    end
                end else begin
                    // wraparound mode rolls through zero here.
                    count <= count - 16'd1;
                    if (count == 16'd1) begin
                        ready <= 1'b1;
                    end
                end
            end
        end else begin
            // stopped, track the reload register.
            count <= counter_reload;
        end
    end

endmodule

//--- src/timer_top.sv
module timer_top
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        ce,
    input  logic        regwr,
    input  logic        regrd,
    input  logic [3:0]  addr,
    input  logic [15:0] data_i,
    output logic [15:0] data_o
);

    reg_sel_t    reg_sel;
    logic [15:0] counter_reload;
    logic        ctl_read_ack;
    logic [15:0] count;
    logic [6:0]  control;
    logic        ready;
    logic        counting;
    logic        ctl_div16;
    logic        ctl_div4;
    logic        count_pulse;

    timer_regs regs_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .ce             (ce),
        .regwr          (regwr),
        .regrd          (regrd),
        .addr           (addr),
        .data_i         (data_i),
        .count          (count),
        .control        (control),
        .ready          (ready),
        .data_o         (data_o),
        .reg_sel        (reg_sel),
        .counter_reload (counter_reload),
        .ctl_read_ack   (ctl_read_ack)
    );

    timer_tick_gen tick_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .counting    (counting),
        .ctl_div16   (ctl_div16),
        .ctl_div4    (ctl_div4),
        .count_pulse (count_pulse)
    );

    timer_counter counter_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .ce             (ce),
        .regwr          (regwr),
        .regrd          (regrd),
        .reg_sel        (reg_sel),
        .data_i         (data_i),
        .counter_reload (counter_reload),
        .ctl_read_ack   (ctl_read_ack),
        .count_pulse    (count_pulse),
        .count          (count),
        .control        (control),
        .ready          (ready),
        .counting       (counting),
        .ctl_div16      (ctl_div16),
        .ctl_div4       (ctl_div4)
    );

endmodule

//--- sim/timer_assertions.sv
module timer_assertions
    import timer_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input logic        ctl_access,
    input logic        count_pulse,
    input logic        counting,
    input logic [15:0] count,
    input logic [6:0]  control,
    input logic        ready,
    input logic [15:0] counter_reload
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run.
    int fail_count = 0;

    // first edge out of reset still shows the reset state.
    count_zero_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> (count == 16'd0)
    ) else begin
        fail_count++;
        $error("count not zero in the first cycle after reset");
    end

    // a pulse that is not masked by a bus access.
    pulse_decrements: assert property (
        @(posedge clk) disable iff (!reset_n)
        (count_pulse && !ctl_access && count != 16'd0)
            |=> (count == $past(count) - 16'd1)
    ) else begin
        fail_count++;
        $error("count pulse with nonzero count did not decrement by one");
    end

    ready_only_at_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(ready) |-> (count == 16'd0)
    ) else begin
        fail_count++;
        $error("ready rose while count is not zero");
    end

    // restart at zero in one-shot mode.
    oneshot_clears_run: assert property (
        @(posedge clk) disable iff (!reset_n)
        (count_pulse && !ctl_access && count == 16'd0
            && !control[bit_wraparound] && control[bit_oneshot])
            |=> !control[bit_run]
    ) else begin
        fail_count++;
        $error("one-shot restart left RUN set");
    end

    stopped_tracks_reload: assert property (
        @(posedge clk) disable iff (!reset_n)
        (!counting && !ctl_access) |=> (count == $past(counter_reload))
    ) else begin
        fail_count++;
        $error("stopped counter does not follow the reload register");
    end

endmodule

bind timer_counter timer_assertions checks_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .ctl_access     (ctl_access),
    .count_pulse    (count_pulse),
    .counting       (counting),
    .count          (count),
    .control        (control),
    .ready          (ready),
    .counter_reload (counter_reload)
);

//--- sim/timer_tb.sv
module timer_tb
    import timer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] upper       = 16'hff00;
    localparam logic [15:0] ready_w     = 16'(1 << bit_done);
    localparam logic [15:0] ctl_run     = 16'(1 << bit_run);
    localparam logic [15:0] ctl_stop    = 16'(1 << bit_stop);
    localparam logic [15:0] ctl_wrap    = 16'(1 << bit_wraparound);
    localparam logic [15:0] ctl_oneshot = 16'(1 << bit_oneshot);
    localparam logic [15:0] ctl_div4_w  = 16'(1 << bit_div4);

    logic        clk = 1'b0;
    logic        reset_n;
    logic        ce;
    logic        regwr;
    logic        regrd;
    logic [3:0]  addr;
    logic [15:0] data_i;
    logic [15:0] data_o;

    int          mismatches = 0;
    int          timeouts = 0;
    int          assert_fails = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'd19179;

    timer_top dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .ce      (ce),
        .regwr   (regwr),
        .regrd   (regrd),
        .addr    (addr),
        .data_i  (data_i),
        .data_o  (data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // tasks start and end on a falling edge.
    task automatic bus_write(input logic [3:0] a, input logic [15:0] d, input logic en);
        ce = en;
        regwr = 1'b1;
        addr = a;
        data_i = d;
        @(negedge clk);
        regwr = 1'b0;
        ce = 1'b1;
    endtask

    task automatic bus_read(input logic [3:0] a, input logic en, output logic [15:0] value);
        ce = en;
        regrd = 1'b1;
        addr = a;
        @(negedge clk);
        regrd = 1'b0;
        ce = 1'b1;
        value = data_o;
    endtask

    task automatic expect_equal(input logic [15:0] got, input logic [15:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic read_expect(input logic [3:0] a, input logic [15:0] exp, input string what);
        logic [15:0] value;
        bus_read(a, 1'b1, value);
        expect_equal(value, exp, what);
    endtask

    // poll the counter register once per cycle.
    task automatic wait_counter(input logic [15:0] exp, input int limit, input string what);
        logic [15:0] value;
        int          tries;
        tries = 0;
        value = ~exp;
        while (value !== exp && tries < limit) begin
            bus_read(addr_counter, 1'b1, value);
            tries++;
        end
        if (value !== exp) begin
            $display("timeout: counter never read %h during %s within %0d cycles",
                     exp, what, limit);
            timeouts++;
        end
    endtask

    task automatic reset_readback();
        logic [15:0] value;
        logic [15:0] got;
        read_expect(addr_reload, 16'h0000, "reload after reset");
        read_expect(addr_counter, 16'h0000, "counter after reset");
        read_expect(addr_control, upper, "control after reset");
        value = 16'h0100 + (next_random() % 16'h0f00);
        bus_write(addr_reload, value, 1'b1);
        read_expect(addr_reload, value, "reload read-back");
        read_expect(addr_counter, value, "counter follows reload");
        // strobes with ce low are ignored.
        bus_write(addr_reload, ~value, 1'b0);
        bus_write(addr_control, ctl_run, 1'b0);
        bus_read(addr_control, 1'b0, got);
        expect_equal(got, value, "data_o held with ce low");
        read_expect(addr_reload, value, "reload after ce low write");
        read_expect(addr_control, upper, "control after ce low write");
    endtask

    task automatic stopped_tracking();
        logic [15:0] value;
        value = 16'h0100 + (next_random() % 16'h0f00);
        bus_write(addr_reload, value, 1'b1);
        idle(2);
        read_expect(addr_counter, value, "counter while stopped");
    endtask

    task automatic periodic_countdown();
        logic [15:0] n;
        n = 16'd2 + (next_random() % 16'd4);
        bus_write(addr_reload, n, 1'b1);
        bus_write(addr_control, ctl_run, 1'b1);
        read_expect(addr_counter, n, "counter at start");
        wait_counter(n - 16'd1, 2 * tick_period, "first count");
        wait_counter(16'd0, (int'(n) + 2) * tick_period, "periodic countdown");
        read_expect(addr_control, upper | ready_w | ctl_run, "control with ready");
        read_expect(addr_control, upper | ctl_run, "control after ready read");
        wait_counter(n, 2 * tick_period, "periodic reload");
        bus_write(addr_control, 16'h0000, 1'b1);
    endtask

    task automatic oneshot_run();
        logic [15:0] n;
        n = 16'd2 + (next_random() % 16'd4);
        bus_write(addr_reload, n, 1'b1);
        bus_write(addr_control, ctl_run | ctl_oneshot, 1'b1);
        wait_counter(16'd0, (int'(n) + 2) * tick_period, "one-shot countdown");
        read_expect(addr_control, upper | ready_w | ctl_run | ctl_oneshot, "one-shot ready");
        wait_counter(n, 2 * tick_period, "one-shot reload");
        read_expect(addr_control, upper | ctl_oneshot, "one-shot run cleared");
        read_expect(addr_counter, n, "counter after one-shot");
        bus_write(addr_control, 16'h0000, 1'b1);
    endtask

    task automatic prescaler_and_stop();
        int start;
        int elapsed;
        bus_write(addr_reload, 16'd2, 1'b1);
        start = cycle_count;
        bus_write(addr_control, ctl_run | ctl_div4_w, 1'b1);
        wait_counter(16'd0, 18 * tick_period, "div4 countdown");
        elapsed = cycle_count - start;
        if (elapsed < 8 * tick_period) begin
            $display("MISMATCH at %0t: div4 countdown took %0d cycles, expected at least %0d",
                     $time, elapsed, 8 * tick_period);
            mismatches++;
        end
        read_expect(addr_control, upper | ready_w | ctl_run | ctl_div4_w, "div4 ready");
        bus_write(addr_control, ctl_run | ctl_div4_w | ctl_stop, 1'b1);
        // spans more than one div4 pulse interval.
        for (int i = 0; i < 4; i++) begin
            idle(3 * tick_period);
            read_expect(addr_counter, 16'd2, "counter with stop");
        end
        read_expect(addr_control, upper | ctl_run | ctl_div4_w | ctl_stop, "control with stop");
        bus_write(addr_control, 16'h0000, 1'b1);
    endtask

    task automatic wraparound_and_zero();
        bus_write(addr_reload, 16'd1, 1'b1);
        bus_write(addr_control, ctl_run | ctl_wrap, 1'b1);
        wait_counter(16'd0, 3 * tick_period, "wraparound countdown");
        wait_counter(16'hffff, 2 * tick_period, "wraparound past zero");
        read_expect(addr_control, upper | ready_w | ctl_run | ctl_wrap, "wraparound ready");
        bus_write(addr_control, 16'h0000, 1'b1);
        // zero reload restarts at a full period.
        bus_write(addr_reload, 16'd0, 1'b1);
        idle(2);
        read_expect(addr_counter, 16'd0, "counter with zero reload");
        bus_write(addr_control, ctl_run, 1'b1);
        wait_counter(16'hffff, 2 * tick_period, "zero reload restart");
        read_expect(addr_control, upper | ctl_run, "control after zero reload");
        bus_write(addr_control, 16'h0000, 1'b1);
    endtask

    initial begin
        reset_n = 1'b0;
        ce = 1'b0;
        regwr = 1'b0;
        regrd = 1'b0;
        addr = 4'd0;
        data_i = 16'd0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        ce = 1'b1;
        idle(2);
        reset_readback();
        stopped_tracking();
        periodic_countdown();
        oneshot_run();
        prescaler_and_stop();
        wraparound_and_zero();
        idle(4);
        assert_fails = dut_i.counter_i.checks_i.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches + timeouts + assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
src/timer_pkg.sv
src/timer_regs.sv
src/timer_tick_gen.sv
src/timer_counter.sv
src/timer_top.sv
sim/timer_assertions.sv
sim/timer_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module timer_tb -f files.f -o timer_sim

# the log decides the result, so a nonzero exit here must not end the script
./obj_dir/timer_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
    echo "run ended without a result line, see sim.log"
    exit 1
fi

exit 0
